// ==== hdl/div_iter.sv ====
////////////////////////////////////////////////////////////////////////////
// restoring divider, one divide at a time; requests arriving while not idle
// are ignored. divide by zero gives quotient all ones, remainder = dividend
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module div_iter (
   input  logic                 aclk,
   input  logic                 rst,
   input  muldiv_pkg::div_req_t div_req,
   output hilo_pkg::hilo_wr_t   div_wr,
   output logic                 div_busy
);

   typedef enum logic [1:0] {
      IDLE,
      STEP,
      FIX,
      WRITE
   } state_e;

   state_e      state;
   logic [4:0]  count;      // step index
   logic        wr_q;       // result valid for hilo_regs
   logic [31:0] dvd_raw;    // original dividend, kept for divide by zero
   logic [31:0] dvs_mag;
   logic [31:0] quot;       // shifts out dividend bits, shifts in quotient
   logic [31:0] rem;
   logic        q_neg;
   logic        r_neg;
   logic        dvs_zero;
   logic        dvd_sign;
   logic        dvs_sign;
   logic [32:0] shifted;
   logic [33:0] diff;

   assign dvd_sign = div_req.is_signed & div_req.dividend[31];
   assign dvs_sign = div_req.is_signed & div_req.divisor[31];

   // one restoring step
   assign shifted = {rem, quot[31]};
   assign diff = {1'b0, shifted} - {2'b00, dvs_mag};

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         state <= IDLE;
         count <= '0;
         wr_q <= 1'b0;
      end else begin
         wr_q <= (state == WRITE);
         case (state)
            IDLE: begin
               if (div_req.valid) begin
                  state <= STEP;
                  count <= '0;
               end
            end
            STEP: begin
               count <= count + 5'd1;
               if (count == 5'(muldiv_pkg::div_steps - 1)) begin
                  state <= FIX;
               end
            end
            FIX:   state <= WRITE;
            WRITE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // datapath
   always_ff @(posedge aclk) begin
      case (state)
         IDLE: begin
            if (div_req.valid) begin
               dvd_raw <= div_req.dividend;
               quot <= dvd_sign ? -div_req.dividend : div_req.dividend;
               dvs_mag <= dvs_sign ? -div_req.divisor : div_req.divisor;
               rem <= '0;
               q_neg <= dvd_sign ^ dvs_sign;
               r_neg <= dvd_sign;   // remainder follows the dividend
               dvs_zero <= (div_req.divisor == '0);
            end
         end
         STEP: begin
            if (!diff[33]) begin
               rem <= diff[31:0];
               quot <= {quot[30:0], 1'b1};
            end else begin
               rem <= shifted[31:0];
               quot <= {quot[30:0], 1'b0};
            end
         end
         FIX: begin
            if (dvs_zero) begin
               quot <= '1;
               rem <= dvd_raw;
            end else begin
               quot <= q_neg ? -quot : quot;   // min / -1 wraps to min
               rem <= r_neg ? -rem : rem;
            end
         end
         default: ;   // hold result during the write
      endcase
   end

   // stays high through the cycle in which HI/LO take the result
   assign div_busy = (state != IDLE) | wr_q;

   always_comb begin
      div_wr.we_hi = wr_q;
      div_wr.we_lo = wr_q;
      div_wr.hi = rem;
      div_wr.lo = quot;
      div_wr.done = wr_q;
   end

endmodule

// ==== hdl/hilo_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// HI/LO write record shared by the multiplier, divider and move path
////////////////////////////////////////////////////////////////////////////

package hilo_pkg;

   typedef struct packed {
      logic                          we_hi;
      logic                          we_lo;
      logic [muldiv_pkg::data_w-1:0] hi;
      logic [muldiv_pkg::data_w-1:0] lo;
      logic                          done;   // completes one issued op
   } hilo_wr_t;

   // write sources, listed in falling priority
   typedef enum logic [1:0] {
      DIV  = 2'd0,
      MUL  = 2'd1,
      MOVE = 2'd2
   } hilo_src_e;

endpackage

// ==== hdl/hilo_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// architectural HI/LO; one write per cycle, divider first, then multiplier
// then move. a losing write is lost, the issuer keeps them apart
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module hilo_regs (
   input  logic               aclk,
   input  logic               rst,
   input  hilo_pkg::hilo_wr_t mul_wr,
   input  hilo_pkg::hilo_wr_t div_wr,
   input  hilo_pkg::hilo_wr_t move_wr,
   output logic [31:0]        hi,
   output logic [31:0]        lo,
   output logic               done
);

   hilo_pkg::hilo_src_e src;
   hilo_pkg::hilo_wr_t  sel;

   always_comb begin
      if (div_wr.done) begin
         src = hilo_pkg::DIV;
      end else if (mul_wr.done) begin
         src = hilo_pkg::MUL;
      end else begin
         src = hilo_pkg::MOVE;   // also the idle choice, enables are low
      end
   end

   always_comb begin
      case (src)
         hilo_pkg::DIV: sel = div_wr;
         hilo_pkg::MUL: sel = mul_wr;
         default:       sel = move_wr;
      endcase
   end

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         hi <= '0;
         lo <= '0;
         done <= 1'b0;
      end else begin
         if (sel.we_hi) begin
            hi <= sel.hi;
         end
         if (sel.we_lo) begin
            lo <= sel.lo;
         end
         done <= sel.done;   // pulse in the cycle after the write
      end
   end

endmodule

// ==== hdl/mul_pipe.sv ====
////////////////////////////////////////////////////////////////////////////
// two-stage multiplier that accepts a new request every cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mul_pipe (
   input  logic                 aclk,
   input  logic                 rst,
   input  muldiv_pkg::mul_req_t mul_req,
   output hilo_pkg::hilo_wr_t   mul_wr
);

   logic signed [65:0] prod_s1;   // full 33x33 product
   logic               valid_s1;
   logic [31:0]        hi_s2;
   logic [31:0]        lo_s2;
   logic               valid_s2;

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         valid_s1 <= 1'b0;
         valid_s2 <= 1'b0;
      end else begin
         valid_s1 <= mul_req.valid;
         valid_s2 <= valid_s1;
      end
   end

   // stage one multiplies the extended operands
   always_ff @(posedge aclk) begin
      if (mul_req.valid) begin
         prod_s1 <= 66'($signed(mul_req.a)) * 66'($signed(mul_req.b));
      end
   end

   // stage two keeps the low 64 bits as HI and LO
   always_ff @(posedge aclk) begin
      if (valid_s1) begin
         hi_s2 <= prod_s1[63:32];
         lo_s2 <= prod_s1[31:0];
      end
   end

   always_comb begin
      mul_wr.we_hi = valid_s2;
      mul_wr.we_lo = valid_s2;
      mul_wr.hi = hi_s2;
      mul_wr.lo = lo_s2;
      mul_wr.done = valid_s2;
   end

endmodule

// ==== hdl/muldiv_issue.sv ====
////////////////////////////////////////////////////////////////////////////
// issue side; an issue strobe seen while busy is high is dropped silently
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module muldiv_issue (
   input  logic                   aclk,
   input  logic                   rst,
   input  logic                   issue,
   input  muldiv_pkg::muldiv_op_e op,
   input  logic [31:0]            a,
   input  logic [31:0]            b,
   input  logic                   div_busy,
   output muldiv_pkg::mul_req_t   mul_req,
   output muldiv_pkg::div_req_t   div_req,
   output hilo_pkg::hilo_wr_t     move_wr,
   output logic                   busy
);

   logic        accept;
   logic        is_mul;
   logic        is_div;
   logic        is_move;
   logic        is_signed;
   logic [32:0] ext_a;
   logic [32:0] ext_b;

   // divider busy comes one edge late, the launched request covers that gap
   assign busy = div_req.valid | div_busy;
   assign accept = issue & ~busy;

   always_comb begin
      is_mul = 1'b0;
      is_div = 1'b0;
      is_move = 1'b0;
      is_signed = 1'b0;
      case (op)
         muldiv_pkg::MULT: begin
            is_mul = 1'b1;
            is_signed = 1'b1;
         end
         muldiv_pkg::MULTU: is_mul = 1'b1;
         muldiv_pkg::DIV: begin
            is_div = 1'b1;
            is_signed = 1'b1;
         end
         muldiv_pkg::DIVU: is_div = 1'b1;
         muldiv_pkg::MTHI,
         muldiv_pkg::MTLO: is_move = 1'b1;
         default: ;   // NOP
      endcase
   end

   // sign extension only for MULT
   assign ext_a = {is_signed & a[31], a};
   assign ext_b = {is_signed & b[31], b};

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         mul_req <= '0;
         div_req <= '0;
         move_wr <= '0;
      end else begin
         mul_req.valid <= accept & is_mul;
         mul_req.a <= ext_a;
         mul_req.b <= ext_b;
         div_req.valid <= accept & is_div;
         div_req.is_signed <= is_signed;
         div_req.dividend <= a;
         div_req.divisor <= b;
         move_wr.we_hi <= accept & (op == muldiv_pkg::MTHI);
         move_wr.we_lo <= accept & (op == muldiv_pkg::MTLO);
         move_wr.hi <= a;   // both words carry operand a
         move_wr.lo <= a;
         move_wr.done <= accept & is_move;
      end
   end

endmodule

// ==== hdl/muldiv_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// operation encoding, widths and latencies of the multiply/divide unit
// latencies count edges from the issue edge to the HI/LO write
////////////////////////////////////////////////////////////////////////////

package muldiv_pkg;

   localparam int data_w = 32;      // operand and HI/LO word width
   localparam int div_steps = 32;   // one quotient bit per step
   localparam int mul_latency = 3;
   localparam int div_latency = 36;

   typedef enum logic [2:0] {
      NOP   = 3'd0,
      MULT  = 3'd1,
      MULTU = 3'd2,
      DIV   = 3'd3,
      DIVU  = 3'd4,
      MTHI  = 3'd5,
      MTLO  = 3'd6
   } muldiv_op_e;

   // operands already extended to 33 bits, so the multiplier is always signed
   typedef struct packed {
      logic              valid;
      logic [data_w:0]   a;
      logic [data_w:0]   b;
   } mul_req_t;

   typedef struct packed {
      logic              valid;
      logic              is_signed;   // DIV when set, DIVU otherwise
      logic [data_w-1:0] dividend;
      logic [data_w-1:0] divisor;
   } div_req_t;

endpackage

// ==== hdl/muldiv_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// multiply/divide unit with HI/LO; issue only while busy is low
// no ordering between a move and a multiply still in flight
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module muldiv_unit (
   input  logic                   aclk,
   input  logic                   rst,
   input  logic                   issue,
   input  muldiv_pkg::muldiv_op_e op,
   input  logic [31:0]            a,
   input  logic [31:0]            b,
   output logic [31:0]            hi,
   output logic [31:0]            lo,
   output logic                   busy,
   output logic                   done
);

   muldiv_pkg::mul_req_t mul_req;
   muldiv_pkg::div_req_t div_req;
   hilo_pkg::hilo_wr_t   move_wr;
   hilo_pkg::hilo_wr_t   mul_wr;
   hilo_pkg::hilo_wr_t   div_wr;
   logic                 div_busy;

   muldiv_issue u_issue (
      .aclk     (aclk),
      .rst      (rst),
      .issue    (issue),
      .op       (op),
      .a        (a),
      .b        (b),
      .div_busy (div_busy),
      .mul_req  (mul_req),
      .div_req  (div_req),
      .move_wr  (move_wr),
      .busy     (busy)
   );

   mul_pipe u_mul (
      .aclk    (aclk),
      .rst     (rst),
      .mul_req (mul_req),
      .mul_wr  (mul_wr)
   );

   div_iter u_div (
      .aclk     (aclk),
      .rst      (rst),
      .div_req  (div_req),
      .div_wr   (div_wr),
      .div_busy (div_busy)
   );

   hilo_regs u_hilo (
      .aclk    (aclk),
      .rst     (rst),
      .mul_wr  (mul_wr),
      .div_wr  (div_wr),
      .move_wr (move_wr),
      .hi      (hi),
      .lo      (lo),
      .done    (done)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert --top-module muldiv_tb \
      -f vlog.f -o muldiv_sim; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/muldiv_sim > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error status"
   exit 1
fi

cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
   exit 1
fi

exit 0

// ==== tests/muldiv_props.sv ====
////////////////////////////////////////////////////////////////////////////
// issue and busy protocol of the multiply/divide unit, bound to its top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module muldiv_props (
   input logic                   aclk,
   input logic                   rst,
   input logic                   issue,
   input muldiv_pkg::muldiv_op_e op,
   input logic                   busy,
   input logic                   done
);

   logic                             fire;       // issue the unit accepts
   logic                             is_div_op;
   logic                             is_mul_op;
   logic [muldiv_pkg::div_latency:0] div_hist;   // bit k set k edges after a divide issue
   logic [muldiv_pkg::mul_latency:0] mul_hist;

   assign fire = issue & ~busy;
   assign is_div_op = (op == muldiv_pkg::DIV) | (op == muldiv_pkg::DIVU);
   assign is_mul_op = (op == muldiv_pkg::MULT) | (op == muldiv_pkg::MULTU);

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         div_hist <= '0;
         mul_hist <= '0;
      end else begin
         div_hist <= {div_hist[muldiv_pkg::div_latency-1:0], fire & is_div_op};
         mul_hist <= {mul_hist[muldiv_pkg::mul_latency-1:0], fire & is_mul_op};
      end
   end

   no_issue_while_busy: assert property (@(posedge aclk) disable iff (!rst) !(issue && busy))
      else $error("issue strobe raised while busy");

   div_done_latency: assert property (
      @(posedge aclk) disable iff (!rst) div_hist[muldiv_pkg::div_latency] |-> done)
      else $error("divide did not complete at its fixed latency");

   mul_done_latency: assert property (
      @(posedge aclk) disable iff (!rst) mul_hist[muldiv_pkg::mul_latency] |-> done)
      else $error("multiply did not complete at its fixed latency");

   idle_after_reset: assert property (@(posedge aclk) $rose(rst) |-> !busy && !done)
      else $error("busy or done high right after reset");

endmodule

bind muldiv_unit muldiv_props u_props (
   .aclk  (aclk),
   .rst   (rst),
   .issue (issue),
   .op    (op),
   .busy  (busy),
   .done  (done)
);

// ==== tests/muldiv_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// ops are issued only while the unit is idle, apart from one burst of
// back-to-back multiplies, so results always complete in issue order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module muldiv_tb;

   localparam int n_corner = 5;
   localparam int n_mul_rand = 10;   // MULT/MULTU pairs
   localparam int n_b2b = 8;
   localparam int n_div_rand = 8;    // DIV/DIVU pairs
   localparam int n_div_special = 8;
   localparam int n_moves = 6;
   localparam int move_latency = 1;
   localparam int n_tests = 2 * n_corner * n_corner + 2 * n_mul_rand + n_b2b
                          + 2 * n_div_rand + n_div_special + n_moves;
   localparam int timeout_cycles = n_tests * muldiv_pkg::div_latency + 200;

   typedef struct packed {
      logic        is_div;
      logic [31:0] due;   // cycle of the expected done pulse
      logic [31:0] hi;
      logic [31:0] lo;
   } exp_t;

   logic                   aclk;
   logic                   rst;
   logic                   issue;
   muldiv_pkg::muldiv_op_e op;
   logic [31:0]            a;
   logic [31:0]            b;
   logic [31:0]            hi;
   logic [31:0]            lo;
   logic                   busy;
   logic                   done;

   int          cycle = 0;
   int          seed = 42;
   int          value_errs = 0;
   int          proto_errs = 0;
   logic [31:0] model_hi = '0;       // HI/LO after every issued op
   logic [31:0] model_lo = '0;
   logic [31:0] committed_hi = '0;   // HI/LO after every completed op
   logic [31:0] committed_lo = '0;
   exp_t        exp_q[$];
   logic [31:0] corner_vals [0:4] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};

   muldiv_unit DUT (
      .aclk  (aclk),
      .rst   (rst),
      .issue (issue),
      .op    (op),
      .a     (a),
      .b     (b),
      .hi    (hi),
      .lo    (lo),
      .busy  (busy),
      .done  (done)
   );

   initial begin
      aclk = 1'b0;
      forever #2 aclk = ~aclk;
   end

   always @(posedge aclk) cycle <= cycle + 1;

   // expected {HI, LO} straight from the MIPS rules
   function automatic logic [63:0] model_op(
      input muldiv_pkg::muldiv_op_e kind,
      input logic [31:0]            x,
      input logic [31:0]            y,
      input logic [31:0]            prev_hi,
      input logic [31:0]            prev_lo
   );
      longint      sx;
      longint      sy;
      int          q;
      int          r;
      logic [63:0] res;
      sx = longint'($signed(x));
      sy = longint'($signed(y));
      res = {prev_hi, prev_lo};
      case (kind)
         muldiv_pkg::MULT:  res = sx * sy;
         muldiv_pkg::MULTU: res = {32'h0, x} * {32'h0, y};
         muldiv_pkg::DIV: begin
            if (y == 32'h0) begin
               res = {x, 32'hffffffff};
            end else if (x == 32'h80000000 && y == 32'hffffffff) begin
               res = {32'h0, x};   // overflow case
            end else begin
               q = $signed(x) / $signed(y);   // truncates toward zero
               r = $signed(x) % $signed(y);
               res = {r, q};
            end
         end
         muldiv_pkg::DIVU: begin
            if (y == 32'h0) begin
               res = {x, 32'hffffffff};
            end else begin
               res = {x % y, x / y};
            end
         end
         muldiv_pkg::MTHI: res = {x, prev_lo};
         muldiv_pkg::MTLO: res = {prev_hi, x};
         default: ;
      endcase
      return res;
   endfunction

   // corner value about one time in three
   function automatic logic [31:0] pick_operand();
      logic [31:0] r;
      r = $random(seed);
      if (r[3:0] < 4'd5) begin
         return corner_vals[r[2:0]];
      end
      return $random(seed);
   endfunction

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%08h got 0x%08h at cycle %0d", name, exp, act, cycle);
         value_errs = value_errs + 1;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%0h got 0x%0h at cycle %0d", name, exp, act, cycle);
         value_errs = value_errs + 1;
      end
   endtask

   task automatic issue_op(
      input muldiv_pkg::muldiv_op_e kind,
      input logic [31:0]            x,
      input logic [31:0]            y
   );
      exp_t        e;
      logic [63:0] res;
      int          lat;
      res = model_op(kind, x, y, model_hi, model_lo);
      model_hi = res[63:32];
      model_lo = res[31:0];
      e.is_div = (kind == muldiv_pkg::DIV) || (kind == muldiv_pkg::DIVU);
      if (e.is_div) begin
         lat = muldiv_pkg::div_latency;
      end else if (kind == muldiv_pkg::MULT || kind == muldiv_pkg::MULTU) begin
         lat = muldiv_pkg::mul_latency;
      end else begin
         lat = move_latency;
      end
      e.due = cycle + 1 + lat;   // DUT samples issue at the next edge
      e.hi = res[63:32];
      e.lo = res[31:0];
      exp_q.push_back(e);
      issue = 1'b1;
      op = kind;
      a = x;
      b = y;
      @(posedge aclk);
      #0.5;
      issue = 1'b0;
   endtask

   task automatic wait_idle();
      while (exp_q.size() != 0 || busy) begin
         @(posedge aclk);
         #0.5;
      end
   endtask

   task automatic run_op(
      input muldiv_pkg::muldiv_op_e kind,
      input logic [31:0]            x,
      input logic [31:0]            y
   );
      issue_op(kind, x, y);
      wait_idle();
   endtask

   task automatic end_run(input logic timed_out);
      $display("checks done: %0d value errors, %0d protocol errors, %0d ops outstanding",
               value_errs, proto_errs, exp_q.size());
      if (timed_out || value_errs != 0 || proto_errs != 0 || exp_q.size() != 0) begin
         $display("STATUS: FAIL");
      end else begin
         $display("STATUS: PASS");
      end
      $finish;
   endtask

   // compare process, outputs are stable at the falling edge
   always @(negedge aclk) begin : compare
      exp_t head;
      logic exp_done;
      logic exp_busy;
      if (!rst) begin
         check_word("hi", 32'h0, hi);
         check_word("lo", 32'h0, lo);
         check_flag("busy", 1'b0, busy);
         check_flag("done", 1'b0, done);
      end else if (done && exp_q.size() == 0) begin
         $display("done pulse at cycle %0d with no operation outstanding", cycle);
         proto_errs = proto_errs + 1;
      end else begin
         exp_done = 1'b0;
         exp_busy = 1'b0;
         if (exp_q.size() != 0) begin
            head = exp_q[0];
            exp_done = (head.due == cycle);
            exp_busy = head.is_div && (cycle >= head.due - muldiv_pkg::div_latency)
                       && (cycle < head.due);
         end
         check_flag("done", exp_done, done);
         check_flag("busy", exp_busy, busy);
         if (done) begin
            head = exp_q.pop_front();
            committed_hi = head.hi;
            committed_lo = head.lo;
         end
         check_word("hi", committed_hi, hi);   // untouched word must hold
         check_word("lo", committed_lo, lo);
      end
   end

   initial begin
      wait (cycle >= timeout_cycles);
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      end_run(1'b1);
   end

   initial begin : stimulus
      int          i;
      int          j;
      logic [31:0] x;
      logic [31:0] y;
      rst = 1'b0;
      issue = 1'b0;
      op = muldiv_pkg::NOP;
      a = '0;
      b = '0;
      repeat (8) @(posedge aclk);
      #0.5;
      rst = 1'b1;
      repeat (3) @(posedge aclk);   // idle state checked at each falling edge
      #0.5;
      for (i = 0; i < n_corner; i++) begin
         for (j = 0; j < n_corner; j++) begin
            run_op(muldiv_pkg::MULT, corner_vals[i], corner_vals[j]);
            run_op(muldiv_pkg::MULTU, corner_vals[i], corner_vals[j]);
         end
      end
      for (i = 0; i < 2 * n_mul_rand; i++) begin
         x = pick_operand();
         y = pick_operand();
         run_op(i[0] ? muldiv_pkg::MULTU : muldiv_pkg::MULT, x, y);
      end
      // multiply burst, one issue per cycle
      for (i = 0; i < n_b2b; i++) begin
         x = pick_operand();
         y = pick_operand();
         issue_op(i[0] ? muldiv_pkg::MULTU : muldiv_pkg::MULT, x, y);
      end
      wait_idle();
      for (i = 0; i < 2 * n_div_rand; i++) begin
         x = pick_operand();
         y = pick_operand();
         run_op(i[0] ? muldiv_pkg::DIVU : muldiv_pkg::DIV, x, y);
      end
      for (i = 1; i < 4; i++) begin
         run_op(muldiv_pkg::DIV, corner_vals[i], 32'h0);
         run_op(muldiv_pkg::DIVU, corner_vals[i], 32'h0);
      end
      run_op(muldiv_pkg::DIV, 32'h80000000, 32'hffffffff);
      run_op(muldiv_pkg::DIVU, 32'h80000000, 32'hffffffff);
      for (i = 0; i < n_moves; i++) begin
         x = pick_operand();
         y = pick_operand();
         run_op(i[0] ? muldiv_pkg::MTLO : muldiv_pkg::MTHI, x, y);
      end
      wait_idle();
      end_run(1'b0);
   end

endmodule

// ==== vlog.f ====
hdl/muldiv_pkg.sv
hdl/hilo_pkg.sv
hdl/muldiv_issue.sv
hdl/mul_pipe.sv
hdl/div_iter.sv
hdl/hilo_regs.sv
hdl/muldiv_unit.sv
tests/muldiv_props.sv
tests/muldiv_tb.sv
